// File: verilog/csr_pkg.sv
`default_nettype none

package csr_pkg;

    localparam int XLEN       = 32;                 // Data width
    localparam int CSR_ADDR_W = 12;                 // CSR address width

    // Pipeline CSR commands
    typedef enum logic [3:0] {
        CMD_NONE       = 4'd0,
        CMD_READ       = 4'd1,
        CMD_WRITE      = 4'd2,
        CMD_READ_WRITE = 4'd3,
        CMD_READ_SET   = 4'd4,
        CMD_READ_CLEAR = 4'd5
    } csr_cmd_e;

    // Implemented machine-mode CSRs
    typedef enum logic [CSR_ADDR_W-1:0] {
        ADDR_MSTATUS   = 12'h300,
        ADDR_MISA      = 12'h301,
        ADDR_MTVEC     = 12'h305,
        ADDR_MSCRATCH  = 12'h340,
        ADDR_MEPC      = 12'h341,
        ADDR_MCAUSE    = 12'h342,
        ADDR_MTVAL     = 12'h343,
        ADDR_CYCLE     = 12'hB00,
        ADDR_CYCLEH    = 12'hB80,
        ADDR_INSTRET   = 12'hB02,
        ADDR_INSTRETH  = 12'hB82,
        ADDR_MVENDORID = 12'hF11,
        ADDR_MARCHID   = 12'hF12,
        ADDR_MIMPID    = 12'hF13,
        ADDR_MHARTID   = 12'hF14,
        ADDR_PRIV      = 12'hFC0                    // Custom privilege readback
    } csr_addr_e;

    localparam logic [XLEN-1:0] MVENDORID = 32'h0A1A_A1E0;
    localparam logic [XLEN-1:0] MARCHID   = 32'h0000_0001;
    localparam logic [XLEN-1:0] MIMPID    = 32'h0000_0001;
    localparam logic [XLEN-1:0] MHARTID   = 32'h0000_0000;   // Single hart

    localparam logic [1:0] RO_REGION = 2'b11;       // Address bits 11:10 of read-only CSRs

endpackage

`default_nettype wire

// File: verilog/csr_priv_pkg.sv
`default_nettype none

package csr_priv_pkg;

    typedef enum logic [1:0] {
        PRIV_USER       = 2'd0,
        PRIV_SUPERVISOR = 2'd1,
        PRIV_MACHINE    = 2'd3
    } priv_e;

    localparam logic [1:0] MPP_RESERVED = 2'b10;    // Encoding 2 not a legal mode

    // mstatus field positions
    localparam int MSTATUS_TSR    = 22;
    localparam int MSTATUS_TW     = 21;
    localparam int MSTATUS_TVM    = 20;
    localparam int MSTATUS_MXR    = 19;
    localparam int MSTATUS_SUM    = 18;
    localparam int MSTATUS_MPRV   = 17;
    localparam int MSTATUS_MPP_LO = 11;             // MPP occupies 12:11
    localparam int MSTATUS_SPP    = 8;
    localparam int MSTATUS_MPIE   = 7;
    localparam int MSTATUS_SPIE   = 5;
    localparam int MSTATUS_MIE    = 3;
    localparam int MSTATUS_SIE    = 1;

    // MXL=1 (RV32), extensions I, M, S, U; atomic bit 0 left clear
    localparam logic [31:0] MISA_BASE = 32'h4014_1100;

endpackage

`default_nettype wire

// File: verilog/csr_access_if.sv
`timescale 1ns/1ps
`default_nettype none

// One access port between the controller and a register block
interface csr_access_if;

    csr_pkg::csr_addr_e           address;   // Raw CSR address from the pipeline
    logic                         wr_en;     // Valid, checked write this cycle
    logic [csr_pkg::XLEN-1:0]     wr_data;   // Already merged for set/clear
    logic [csr_pkg::XLEN-1:0]     rd_data;   // Zero when not hit
    logic                         hit;       // Block implements address

    modport ctrl (
        output address,
        output wr_en,
        output wr_data,
        input  rd_data,
        input  hit
    );

    // Register block side
    modport regs (
        input  address,
        input  wr_en,
        input  wr_data,
        output rd_data,
        output hit
    );

endinterface

`default_nettype wire

// File: verilog/csr_access_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module csr_access_ctrl (
    input  csr_pkg::csr_cmd_e          cmd,
    input  csr_pkg::csr_addr_e         address,
    input  logic [csr_pkg::XLEN-1:0]   writedata,
    input  csr_priv_pkg::priv_e        privilege,
    output logic [csr_pkg::XLEN-1:0]   readdata,
    output logic                       invalid,
    csr_access_if.ctrl                 status_bus,
    csr_access_if.ctrl                 trap_bus,
    csr_access_if.ctrl                 counter_bus
);

    logic                          is_read;
    logic                          is_write;
    logic [csr_pkg::CSR_ADDR_W-1:0] addr_bits;   // Plain vector view for field checks
    logic                          hit_any;
    logic                          level_violation;
    logic                          ro_violation;
    logic                          unimpl;
    logic [csr_pkg::XLEN-1:0]      merged_data;

    assign addr_bits = address;

    // Command classification
    always_comb begin
        is_read  = 1'b0;
        is_write = 1'b0;
        case (cmd)
            csr_pkg::CMD_READ:       is_read = 1'b1;
            csr_pkg::CMD_WRITE:      is_write = 1'b1;
            csr_pkg::CMD_READ_WRITE,
            csr_pkg::CMD_READ_SET,
            csr_pkg::CMD_READ_CLEAR: begin
                is_read  = 1'b1;
                is_write = 1'b1;
            end
            default: ;                                  // CMD_NONE and unused codes
        endcase
    end

    assign hit_any = status_bus.hit | trap_bus.hit | counter_bus.hit;

    // Required privilege lives in address bits 9:8
    assign level_violation = (is_read || is_write) && (privilege < addr_bits[9:8]);
    assign ro_violation    = is_write && (addr_bits[11:10] == csr_pkg::RO_REGION);
    assign unimpl          = (is_read || is_write) && !hit_any;
    assign invalid         = level_violation || ro_violation || unimpl;

    // Read mux, at most one block hits
    always_comb begin
        if (status_bus.hit)
            readdata = status_bus.rd_data;
        else if (trap_bus.hit)
            readdata = trap_bus.rd_data;
        else if (counter_bus.hit)
            readdata = counter_bus.rd_data;
        else
            readdata = '0;                              // Unimplemented reads as zero
    end

    // Read-modify-write merge against current register value
    always_comb begin
        case (cmd)
            csr_pkg::CMD_READ_SET:   merged_data = readdata | writedata;
            csr_pkg::CMD_READ_CLEAR: merged_data = readdata & ~writedata;
            default:                 merged_data = writedata;   // Write, read-write
        endcase
    end

    // Same request broadcast, owning block picks it up
    assign status_bus.address  = address;
    assign status_bus.wr_en    = is_write && !invalid;
    assign status_bus.wr_data  = merged_data;
    assign trap_bus.address    = address;
    assign trap_bus.wr_en      = is_write && !invalid;
    assign trap_bus.wr_data    = merged_data;
    assign counter_bus.address = address;
    assign counter_bus.wr_en   = is_write && !invalid;
    assign counter_bus.wr_data = merged_data;

endmodule

`default_nettype wire

// File: verilog/csr_status_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_status_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  csr_priv_pkg::priv_e  privilege,
    csr_access_if.regs           bus,
    output logic                 mstatus_tsr,
    output logic                 mstatus_tw,
    output logic                 mstatus_tvm,
    output logic                 mstatus_mxr,
    output logic                 mstatus_sum,
    output logic                 mstatus_mprv,
    output logic [1:0]           mstatus_mpp
);

    logic                      mstatus_spp;
    logic                      mstatus_mpie;
    logic                      mstatus_spie;
    logic                      mstatus_mie;
    logic                      mstatus_sie;
    logic                      misa_atomic;        // Scratch bit for atomic emulation
    logic                      wr_mstatus;
    logic                      wr_misa;
    logic [1:0]                wr_mpp;
    logic [csr_pkg::XLEN-1:0]  mstatus_rd;

    assign wr_mstatus = bus.wr_en && (bus.address == csr_pkg::ADDR_MSTATUS);
    assign wr_misa    = bus.wr_en && (bus.address == csr_pkg::ADDR_MISA);
    assign wr_mpp     = bus.wr_data[csr_priv_pkg::MSTATUS_MPP_LO +: 2];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            {mstatus_tsr, mstatus_tw, mstatus_tvm}   <= '0;
            {mstatus_mxr, mstatus_sum, mstatus_mprv} <= '0;
            mstatus_mpp  <= '0;
            {mstatus_spp, mstatus_mpie, mstatus_spie, mstatus_mie, mstatus_sie} <= '0;
            misa_atomic  <= 1'b0;
        end else begin
            if (wr_mstatus) begin
                mstatus_tsr  <= bus.wr_data[csr_priv_pkg::MSTATUS_TSR];
                mstatus_tw   <= bus.wr_data[csr_priv_pkg::MSTATUS_TW];
                mstatus_tvm  <= bus.wr_data[csr_priv_pkg::MSTATUS_TVM];
                mstatus_mxr  <= bus.wr_data[csr_priv_pkg::MSTATUS_MXR];
                mstatus_sum  <= bus.wr_data[csr_priv_pkg::MSTATUS_SUM];
                mstatus_mprv <= bus.wr_data[csr_priv_pkg::MSTATUS_MPRV];
                if (wr_mpp != csr_priv_pkg::MPP_RESERVED)
                    mstatus_mpp <= wr_mpp;              // Reserved value keeps old MPP
                mstatus_spp  <= bus.wr_data[csr_priv_pkg::MSTATUS_SPP];
                mstatus_mpie <= bus.wr_data[csr_priv_pkg::MSTATUS_MPIE];
                mstatus_spie <= bus.wr_data[csr_priv_pkg::MSTATUS_SPIE];
                mstatus_mie  <= bus.wr_data[csr_priv_pkg::MSTATUS_MIE];
                mstatus_sie  <= bus.wr_data[csr_priv_pkg::MSTATUS_SIE];
            end
            if (wr_misa)
                misa_atomic <= bus.wr_data[0];          // A extension bit
        end
    end

    // mstatus image, unlisted bits read zero
    always_comb begin
        mstatus_rd = '0;
        mstatus_rd[csr_priv_pkg::MSTATUS_TSR]  = mstatus_tsr;
        mstatus_rd[csr_priv_pkg::MSTATUS_TW]   = mstatus_tw;
        mstatus_rd[csr_priv_pkg::MSTATUS_TVM]  = mstatus_tvm;
        mstatus_rd[csr_priv_pkg::MSTATUS_MXR]  = mstatus_mxr;
        mstatus_rd[csr_priv_pkg::MSTATUS_SUM]  = mstatus_sum;
        mstatus_rd[csr_priv_pkg::MSTATUS_MPRV] = mstatus_mprv;
        mstatus_rd[csr_priv_pkg::MSTATUS_MPP_LO +: 2] = mstatus_mpp;
        mstatus_rd[csr_priv_pkg::MSTATUS_SPP]  = mstatus_spp;
        mstatus_rd[csr_priv_pkg::MSTATUS_MPIE] = mstatus_mpie;
        mstatus_rd[csr_priv_pkg::MSTATUS_SPIE] = mstatus_spie;
        mstatus_rd[csr_priv_pkg::MSTATUS_MIE]  = mstatus_mie;
        mstatus_rd[csr_priv_pkg::MSTATUS_SIE]  = mstatus_sie;
    end

    always_comb begin
        bus.hit     = 1'b1;
        bus.rd_data = '0;
        case (bus.address)
            csr_pkg::ADDR_MSTATUS:   bus.rd_data = mstatus_rd;
            csr_pkg::ADDR_MISA:      bus.rd_data = csr_priv_pkg::MISA_BASE | {31'b0, misa_atomic};
            csr_pkg::ADDR_MVENDORID: bus.rd_data = csr_pkg::MVENDORID;
            csr_pkg::ADDR_MARCHID:   bus.rd_data = csr_pkg::MARCHID;
            csr_pkg::ADDR_MIMPID:    bus.rd_data = csr_pkg::MIMPID;
            csr_pkg::ADDR_MHARTID:   bus.rd_data = csr_pkg::MHARTID;
            csr_pkg::ADDR_PRIV:      bus.rd_data = {30'b0, privilege};   // Pipeline's mode
            default:                 bus.hit = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/csr_trap_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_trap_regs (
    input  logic        clk,
    input  logic        rst_n,
    csr_access_if.regs  bus
);

    logic [csr_pkg::XLEN-1:0] mtvec;
    logic [csr_pkg::XLEN-1:0] mscratch;
    logic [csr_pkg::XLEN-1:0] mepc;
    logic [csr_pkg::XLEN-1:0] mcause;
    logic [csr_pkg::XLEN-1:0] mtval;
    logic                     aligned;               // Word-aligned target

    assign aligned = (bus.wr_data[1:0] == 2'b00);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (bus.wr_en) begin
            case (bus.address)
                csr_pkg::ADDR_MTVEC:    if (aligned) mtvec <= bus.wr_data;   // Direct mode only
                csr_pkg::ADDR_MSCRATCH: mscratch <= bus.wr_data;
                csr_pkg::ADDR_MEPC:     if (aligned) mepc <= bus.wr_data;
                csr_pkg::ADDR_MCAUSE:   mcause <= bus.wr_data;
                csr_pkg::ADDR_MTVAL:    mtval <= bus.wr_data;
                default: ;                              // Owned by another block
            endcase
        end
    end

    // Read side
    always_comb begin
        bus.hit     = 1'b1;
        bus.rd_data = '0;
        case (bus.address)
            csr_pkg::ADDR_MTVEC:    bus.rd_data = mtvec;
            csr_pkg::ADDR_MSCRATCH: bus.rd_data = mscratch;
            csr_pkg::ADDR_MEPC:     bus.rd_data = mepc;
            csr_pkg::ADDR_MCAUSE:   bus.rd_data = mcause;
            csr_pkg::ADDR_MTVAL:    bus.rd_data = mtval;
            default:                bus.hit = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/csr_counters.sv
`timescale 1ns/1ps
`default_nettype none

module csr_counters (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        instret_incr,                // One retired instruction
    csr_access_if.regs  bus
);

    logic [63:0] cycle_q;
    logic [63:0] instret_q;
    logic [63:0] cycle_inc;
    logic [63:0] instret_inc;
    logic [63:0] cycle_nxt;
    logic [63:0] instret_nxt;

    assign cycle_inc   = cycle_q + 64'd1;
    assign instret_inc = instret_q + {63'b0, instret_incr};

    // Written half overrides increment, other half keeps counting
    always_comb begin
        cycle_nxt   = cycle_inc;
        instret_nxt = instret_inc;
        if (bus.wr_en) begin
            case (bus.address)
                csr_pkg::ADDR_CYCLE:    cycle_nxt[31:0]    = bus.wr_data;
                csr_pkg::ADDR_CYCLEH:   cycle_nxt[63:32]   = bus.wr_data;
                csr_pkg::ADDR_INSTRET:  instret_nxt[31:0]  = bus.wr_data;
                csr_pkg::ADDR_INSTRETH: instret_nxt[63:32] = bus.wr_data;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_q   <= '0;
            instret_q <= '0;
        end else begin
            cycle_q   <= cycle_nxt;
            instret_q <= instret_nxt;
        end
    end

    always_comb begin
        bus.hit     = 1'b1;
        bus.rd_data = '0;
        case (bus.address)
            csr_pkg::ADDR_CYCLE:    bus.rd_data = cycle_q[31:0];
            csr_pkg::ADDR_CYCLEH:   bus.rd_data = cycle_q[63:32];
            csr_pkg::ADDR_INSTRET:  bus.rd_data = instret_q[31:0];
            csr_pkg::ADDR_INSTRETH: bus.rd_data = instret_q[63:32];
            default:                bus.hit = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/csr_file.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic [3:0]                      cmd,
    input  logic [csr_pkg::CSR_ADDR_W-1:0]  address,
    input  logic [csr_pkg::XLEN-1:0]        writedata,
    input  logic [1:0]                      privilege,     // Current mode from pipeline
    input  logic                            instret_incr,
    output logic [csr_pkg::XLEN-1:0]        readdata,
    output logic                            invalid,
    output logic                            mstatus_tsr,
    output logic                            mstatus_tw,
    output logic                            mstatus_tvm,
    output logic                            mstatus_mxr,
    output logic                            mstatus_sum,
    output logic                            mstatus_mprv,
    output logic [1:0]                      mstatus_mpp
);

    csr_access_if status_bus ();
    csr_access_if trap_bus ();
    csr_access_if counter_bus ();

    // Decode and checks, plain ports cast to package types
    csr_access_ctrl ctrl_i (
        .cmd         (csr_pkg::csr_cmd_e'(cmd)),
        .address     (csr_pkg::csr_addr_e'(address)),
        .writedata   (writedata),
        .privilege   (csr_priv_pkg::priv_e'(privilege)),
        .readdata    (readdata),
        .invalid     (invalid),
        .status_bus  (status_bus.ctrl),
        .trap_bus    (trap_bus.ctrl),
        .counter_bus (counter_bus.ctrl)
    );

    csr_status_regs status_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .privilege    (csr_priv_pkg::priv_e'(privilege)),
        .bus          (status_bus.regs),
        .mstatus_tsr  (mstatus_tsr),
        .mstatus_tw   (mstatus_tw),
        .mstatus_tvm  (mstatus_tvm),
        .mstatus_mxr  (mstatus_mxr),
        .mstatus_sum  (mstatus_sum),
        .mstatus_mprv (mstatus_mprv),
        .mstatus_mpp  (mstatus_mpp)
    );

    csr_trap_regs trap_i (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (trap_bus.regs)
    );

    csr_counters counters_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .instret_incr (instret_incr),
        .bus          (counter_bus.regs)
    );

endmodule

`default_nettype wire

// File: verification/csr_file_tb.sv
`timescale 1ns/1ps
`default_nettype none

module csr_file_tb;

    localparam int MAX_CYCLES = 2000;                      // Stimulus needs about 400 cycles
    localparam logic [31:0] MSTATUS_MASK = 32'h007E_19AA;  // Bits 22:17, 12:11, 8, 7, 5, 3, 1

    logic        clk = 1'b0;
    logic        rst_n;
    logic [3:0]  cmd;
    logic [11:0] address;
    logic [31:0] writedata;
    logic [1:0]  privilege;
    logic        instret_incr;
    logic [31:0] readdata;
    logic        invalid;
    logic        mstatus_tsr;
    logic        mstatus_tw;
    logic        mstatus_tvm;
    logic        mstatus_mxr;
    logic        mstatus_sum;
    logic        mstatus_mprv;
    logic [1:0]  mstatus_mpp;
    logic [7:0]  status_ports;

    // Reference model state, value held during the current cycle
    logic [31:0] m_mstatus;
    logic        m_misa_a;
    logic [31:0] m_mtvec;
    logic [31:0] m_mscratch;
    logic [31:0] m_mepc;
    logic [31:0] m_mcause;
    logic [31:0] m_mtval;
    logic [63:0] m_cycle;
    logic [63:0] m_instret;

    logic [31:0] exp_readdata;
    logic        exp_invalid;
    logic [7:0]  exp_ports;
    int          errors = 0;
    int          cycles = 0;

    logic [11:0] all_addrs [16] = '{12'h300, 12'h301, 12'h305, 12'h340, 12'h341, 12'h342,
                                    12'h343, 12'hB00, 12'hB80, 12'hB02, 12'hB82, 12'hF11,
                                    12'hF12, 12'hF13, 12'hF14, 12'hFC0};
    logic [11:0] scratch_addrs [3] = '{12'h340, 12'h342, 12'h343};

    csr_file csr_file_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .cmd          (cmd),
        .address      (address),
        .writedata    (writedata),
        .privilege    (privilege),
        .instret_incr (instret_incr),
        .readdata     (readdata),
        .invalid      (invalid),
        .mstatus_tsr  (mstatus_tsr),
        .mstatus_tw   (mstatus_tw),
        .mstatus_tvm  (mstatus_tvm),
        .mstatus_mxr  (mstatus_mxr),
        .mstatus_sum  (mstatus_sum),
        .mstatus_mprv (mstatus_mprv),
        .mstatus_mpp  (mstatus_mpp)
    );

    assign status_ports = {mstatus_tsr, mstatus_tw, mstatus_tvm, mstatus_mxr,
                           mstatus_sum, mstatus_mprv, mstatus_mpp};

    always #2 clk = ~clk;                                  // 4 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Responses are combinational, so checked at the edge closing the command's cycle
    read_check: assert property (@(posedge clk) disable iff (!rst_n)
        cmd != csr_pkg::CMD_NONE |-> readdata == exp_readdata)
        else begin
            errors = errors + 1;
            $display("error readdata at %03h: got %08h expected %08h", $sampled(address),
                     $sampled(readdata), $sampled(exp_readdata));
        end

    invalid_check: assert property (@(posedge clk) disable iff (!rst_n)
        cmd != csr_pkg::CMD_NONE |-> invalid == exp_invalid)
        else begin
            errors = errors + 1;
            $display("error invalid at %03h: got %0h expected %0h", $sampled(address),
                     $sampled(invalid), $sampled(exp_invalid));
        end

    ports_check: assert property (@(posedge clk) disable iff (!rst_n)
        status_ports == exp_ports)
        else begin
            errors = errors + 1;
            $display("error mstatus ports: got %02h expected %02h", $sampled(status_ports),
                     $sampled(exp_ports));
        end

    function automatic logic implemented(input logic [11:0] a);
        case (a)
            12'h300, 12'h301, 12'h305, 12'h340, 12'h341, 12'h342, 12'h343,
            12'hB00, 12'hB80, 12'hB02, 12'hB82,
            12'hF11, 12'hF12, 12'hF13, 12'hF14, 12'hFC0: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    // Value the register shows this cycle, zero when not implemented
    function automatic logic [31:0] model_read(input logic [11:0] a, input logic [1:0] p);
        case (a)
            12'h300: return m_mstatus;
            12'h301: return csr_priv_pkg::MISA_BASE | {31'b0, m_misa_a};
            12'h305: return m_mtvec;
            12'h340: return m_mscratch;
            12'h341: return m_mepc;
            12'h342: return m_mcause;
            12'h343: return m_mtval;
            12'hB00: return m_cycle[31:0];
            12'hB80: return m_cycle[63:32];
            12'hB02: return m_instret[31:0];
            12'hB82: return m_instret[63:32];
            12'hF11: return 32'h0A1A_A1E0;
            12'hF12: return 32'd1;
            12'hF13: return 32'd1;
            12'hF14: return 32'd0;
            12'hFC0: return {30'b0, p};                    // Caller's own mode
            default: return 32'd0;
        endcase
    endfunction

    function automatic logic access_invalid(input csr_pkg::csr_cmd_e c, input logic [11:0] a,
                                            input logic [1:0] p);
        logic acc;
        logic wr;
        acc = (c != csr_pkg::CMD_NONE);
        wr  = acc && (c != csr_pkg::CMD_READ);
        return acc && ((p < a[9:8]) || (wr && a[11:10] == 2'b11) || !implemented(a));
    endfunction

    function automatic csr_pkg::csr_cmd_e pick_cmd(input int n);
        case (n)
            0:       return csr_pkg::CMD_READ;
            1:       return csr_pkg::CMD_WRITE;
            2:       return csr_pkg::CMD_READ_WRITE;
            3:       return csr_pkg::CMD_READ_SET;
            default: return csr_pkg::CMD_READ_CLEAR;
        endcase
    endfunction

    // One command per cycle, model advanced to the next cycle's state
    task automatic issue(input csr_pkg::csr_cmd_e c, input logic [11:0] a,
                         input logic [31:0] d, input logic [1:0] p, input logic inc);
        logic [31:0] old;
        logic [31:0] merged;
        logic        bad;
        logic [63:0] cyc_next;
        logic [63:0] ret_next;
        old = model_read(a, p);
        bad = access_invalid(c, a, p);
        cmd          <= c;
        address      <= a;
        writedata    <= d;
        privilege    <= p;
        instret_incr <= inc;
        exp_readdata <= old;
        exp_invalid  <= bad;
        exp_ports    <= {m_mstatus[22:17], m_mstatus[12:11]};
        case (c)
            csr_pkg::CMD_READ_SET:   merged = old | d;
            csr_pkg::CMD_READ_CLEAR: merged = old & ~d;
            default:                 merged = d;
        endcase
        cyc_next = m_cycle + 64'd1;
        ret_next = m_instret + {63'b0, inc};
        if (c != csr_pkg::CMD_NONE && c != csr_pkg::CMD_READ && !bad) begin
            case (a)
                12'h300: begin
                    if (merged[12:11] == 2'b10)
                        merged[12:11] = m_mstatus[12:11];  // Reserved MPP keeps old mode
                    m_mstatus = merged & MSTATUS_MASK;
                end
                12'h301: m_misa_a = merged[0];
                12'h305: if (merged[1:0] == 2'b00) m_mtvec = merged;
                12'h340: m_mscratch = merged;
                12'h341: if (merged[1:0] == 2'b00) m_mepc = merged;
                12'h342: m_mcause = merged;
                12'h343: m_mtval = merged;
                12'hB00: cyc_next[31:0] = merged;          // Write beats increment
                12'hB80: cyc_next[63:32] = merged;
                12'hB02: ret_next[31:0] = merged;
                12'hB82: ret_next[63:32] = merged;
                default: ;
            endcase
        end
        m_cycle   = cyc_next;
        m_instret = ret_next;
        @(posedge clk);
    endtask

    task automatic idle(input int n);
        repeat (n) issue(csr_pkg::CMD_NONE, 12'h000, 32'd0, 2'd3, 1'b0);
    endtask

    initial begin
        logic [11:0] a;
        void'($urandom(32'h89a8349d));
        rst_n        = 1'b0;
        cmd          = 4'd0;
        address      = 12'h000;
        writedata    = 32'd0;
        privilege    = 2'd3;
        instret_incr = 1'b0;
        {m_mstatus, m_misa_a, m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval} = '0;
        m_cycle   = '0;
        m_instret = '0;
        exp_readdata = '0;                                 // Matches reset state of the DUT
        exp_invalid  = 1'b0;
        exp_ports    = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        foreach (all_addrs[i]) issue(csr_pkg::CMD_READ, all_addrs[i], 32'd0, 2'd3, 1'b0);
        // Scratch-type registers, random merge commands
        for (int i = 0; i < 80; i++) begin
            a = scratch_addrs[$urandom_range(0, 2)];
            issue(pick_cmd($urandom_range(0, 4)), a, $urandom, 2'd3, 1'b0);
        end
        // Trap vectors, misaligned writes dropped
        issue(csr_pkg::CMD_WRITE, 12'h305, 32'h0000_1000, 2'd3, 1'b0);
        issue(csr_pkg::CMD_WRITE, 12'h305, 32'h0000_2001, 2'd3, 1'b0);
        for (int i = 0; i < 24; i++) begin
            a = (i % 2 == 1) ? 12'h341 : 12'h305;
            issue(csr_pkg::CMD_WRITE, a, $urandom, 2'd3, 1'b0);
            issue(csr_pkg::CMD_READ, a, 32'd0, 2'd3, 1'b0);
        end
        // mstatus fields and MPP handling
        issue(csr_pkg::CMD_WRITE, 12'h300, 32'hFFFF_FFFF, 2'd3, 1'b0);
        issue(csr_pkg::CMD_WRITE, 12'h300, 32'h0000_1000, 2'd3, 1'b0);   // MPP=2
        issue(csr_pkg::CMD_READ_CLEAR, 12'h300, 32'h0000_1800, 2'd3, 1'b0);
        issue(csr_pkg::CMD_WRITE, 12'h300, 32'h0002_0800, 2'd3, 1'b0);
        issue(csr_pkg::CMD_READ_SET, 12'h300, 32'h0050_0000, 2'd3, 1'b0);
        issue(csr_pkg::CMD_WRITE, 12'h300, 32'h0000_1000, 2'd3, 1'b0);
        idle(2);
        issue(csr_pkg::CMD_WRITE, 12'h301, 32'hFFFF_FFFF, 2'd3, 1'b0);   // Only bit 0 sticks
        issue(csr_pkg::CMD_READ, 12'h301, 32'd0, 2'd3, 1'b0);
        issue(csr_pkg::CMD_READ_CLEAR, 12'h301, 32'h0000_0001, 2'd3, 1'b0);
        issue(csr_pkg::CMD_READ_SET, 12'h301, 32'h0000_0001, 2'd3, 1'b0);
        issue(csr_pkg::CMD_READ, 12'h301, 32'd0, 2'd3, 1'b0);
        // Access checks
        issue(csr_pkg::CMD_WRITE, 12'h300, 32'h0060_0088, 2'd3, 1'b0);
        issue(csr_pkg::CMD_READ, 12'h300, 32'd0, 2'd0, 1'b0);
        issue(csr_pkg::CMD_WRITE, 12'h300, 32'hFFFF_FFFF, 2'd0, 1'b0);
        issue(csr_pkg::CMD_READ_SET, 12'h300, 32'h0000_0002, 2'd1, 1'b0);
        issue(csr_pkg::CMD_READ, 12'h300, 32'd0, 2'd3, 1'b0);
        issue(csr_pkg::CMD_WRITE, 12'hF11, 32'h1234_5678, 2'd3, 1'b0);   // Read-only region
        issue(csr_pkg::CMD_READ, 12'hF11, 32'd0, 2'd3, 1'b0);
        issue(csr_pkg::CMD_READ, 12'h7C0, 32'd0, 2'd3, 1'b0);
        issue(csr_pkg::CMD_WRITE, 12'h7C0, 32'hFFFF_FFFF, 2'd3, 1'b0);
        issue(csr_pkg::CMD_READ, 12'hB00, 32'd0, 2'd0, 1'b0);
        issue(csr_pkg::CMD_READ, 12'hFC0, 32'd0, 2'd0, 1'b0);
        // Counters
        for (int i = 0; i < 4; i++) begin
            issue(csr_pkg::CMD_READ, 12'hB00, 32'd0, 2'd3, 1'b0);
            idle($urandom_range(1, 20));
            issue(csr_pkg::CMD_READ, 12'hB00, 32'd0, 2'd3, 1'b0);
        end
        for (int i = 0; i < 40; i++)
            issue(csr_pkg::CMD_READ, 12'hB02, 32'd0, 2'd3, 1'($urandom_range(0, 1)));
        issue(csr_pkg::CMD_READ, 12'hB82, 32'd0, 2'd3, 1'b0);
        issue(csr_pkg::CMD_WRITE, 12'hB02, 32'h0000_0100, 2'd3, 1'b1);  // Write beats pulse
        issue(csr_pkg::CMD_READ, 12'hB02, 32'd0, 2'd3, 1'b1);
        issue(csr_pkg::CMD_WRITE, 12'hB00, 32'hFFFF_FFF0, 2'd3, 1'b0);
        issue(csr_pkg::CMD_READ, 12'hB00, 32'd0, 2'd3, 1'b0);
        idle(20);                                          // Low half wraps into high
        issue(csr_pkg::CMD_READ, 12'hB80, 32'd0, 2'd3, 1'b0);
        issue(csr_pkg::CMD_WRITE, 12'hB80, 32'h1234_5678, 2'd3, 1'b0);
        issue(csr_pkg::CMD_READ, 12'hB80, 32'd0, 2'd3, 1'b0);
        issue(csr_pkg::CMD_WRITE, 12'hB82, 32'h0000_00A5, 2'd3, 1'b1);
        issue(csr_pkg::CMD_READ, 12'hB82, 32'd0, 2'd3, 1'b0);
        idle(3);                                           // Let last checks fire
        $display("run complete: %0d errors in %0d cycles", errors, cycles);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: csr_file.f
verilog/csr_pkg.sv
verilog/csr_priv_pkg.sv
verilog/csr_access_if.sv
verilog/csr_access_ctrl.sv
verilog/csr_status_regs.sv
verilog/csr_trap_regs.sv
verilog/csr_counters.sv
verilog/csr_file.sv
verification/csr_file_tb.sv
